// ==== ball/ballController.sv ====
`default_nettype none
`include "pinball_defines.svh"

module ballController (
	input  logic                   clk,
	input  logic                   resetN,
	input  logic                   startOfFrame,
	input  logic                   pause,
	input  logic                   resetLevel,
	input  logic                   frameHit,
	input  logic                   bumperHit,
	input  logic                   flipperHit,
	input  logic                   springHit,
	input  logic                   trapActive,
	input  pinballPkg::edgeCode    hitEdge,
	input  pinballPkg::fixedValue  flipperSpeedX,
	input  pinballPkg::fixedValue  springSpeedY,
	input  pinballPkg::screenCoord trapX,
	input  pinballPkg::screenCoord trapY,
	output pinballPkg::screenCoord topLeftX,
	output pinballPkg::screenCoord topLeftY
);
	import pinballPkg::*;

	fixedValue    posX;
	fixedValue    posY;
	fixedValue    speedX;
	fixedValue    speedY;
	fixedValue    nextX;
	cooldownCount bumperCool;
	cooldownCount springCool;

	// Horizontal move that the next frame would make
	assign nextX = posX + speedX;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Position, speed and cooldowns
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			posX       <= `BALL_START_X * `FIXED_SCALE;
			posY       <= `BALL_START_Y * `FIXED_SCALE;
			speedX     <= '0;
			speedY     <= '0;
			bumperCool <= '0;
			springCool <= '0;
		end
		else if (resetLevel) begin
			posX       <= `BALL_START_X * `FIXED_SCALE;
			posY       <= `BALL_START_Y * `FIXED_SCALE;
			speedX     <= '0;
			speedY     <= '0;
			bumperCool <= '0;
			springCool <= '0;
		end
		else if (!pause) begin
			if (trapActive) begin
				// Ball box centred on the trap point
				posX <= (fixedValue'(trapX) - (`BALL_SIZE / 2)) * `FIXED_SCALE;
				posY <= (fixedValue'(trapY) - (`BALL_SIZE / 2)) * `FIXED_SCALE;
			end
			else if (startOfFrame) begin
				speedY <= speedY + `GRAVITY;
				posY   <= posY + speedY;

				// Damp the sideways speed instead of leaving the field
				if ((nextX < 0) || (nextX > (`FIELD_WIDTH * `FIXED_SCALE))) begin
					speedX <= speedX >>> 1;
				end
				else begin
					posX <= nextX;
				end

				if (bumperCool != '0) begin
					bumperCool <= bumperCool - 1'b1;
				end
				if (springCool != '0) begin
					springCool <= springCool - 1'b1;
				end
			end
			else if (frameHit) begin
				if (hitEdge[EDGE_LEFT] && (speedX < 0)) begin
					speedX <= -speedX;
				end
				else if (hitEdge[EDGE_RIGHT] && (speedX > 0)) begin
					speedX <= -speedX;
				end

				if (hitEdge[EDGE_TOP] && (speedY < 0)) begin
					speedY <= -speedY;
				end
				else if (hitEdge[EDGE_BOTTOM] && (speedY > 0)) begin
					speedY <= -speedY;
				end
			end
			else if (springHit && (springCool == '0)) begin
				// Spring sits under the ball and only adds an upward kick
				if (springSpeedY < 0) begin
					speedY <= -speedY + springSpeedY;
				end
				else begin
					speedY <= -speedY;
				end
				springCool <= cooldownCount'(`SPRING_COOLDOWN);
			end
			else if (flipperHit) begin
				// Flipper counts as a bottom-edge hit
				if (speedY > 0) begin
					speedY <= -speedY;
					speedX <= speedX + flipperSpeedX;
				end
			end
			else if (bumperHit && (bumperCool == '0)) begin
				if (hitEdge[EDGE_LEFT] && (speedX < 0)) begin
					speedX <= -(speedX <<< 1);
				end
				else if (hitEdge[EDGE_RIGHT] && (speedX > 0)) begin
					speedX <= -(speedX <<< 1);
				end

				if (hitEdge[EDGE_TOP] && (speedY < 0)) begin
					speedY <= -(speedY <<< 1);
				end
				else if (hitEdge[EDGE_BOTTOM] && (speedY > 0)) begin
					speedY <= -(speedY <<< 1);
				end
				bumperCool <= cooldownCount'(`BUMPER_COOLDOWN);
			end
		end
	end

	// Back to whole pixels
	assign topLeftX = screenCoord'(posX / `FIXED_SCALE);
	assign topLeftY = screenCoord'(posY / `FIXED_SCALE);

endmodule

`default_nettype wire

// ==== ball/collisionUnit.sv ====
`default_nettype none
`include "pinball_defines.svh"

module collisionUnit (
	input  logic                   clk,
	input  logic                   resetN,
	input  logic                   startOfFrame,
	input  pinballPkg::screenCoord topLeftX,
	input  pinballPkg::screenCoord topLeftY,
	output logic                   frameHit,
	output logic                   bumperHit,
	output pinballPkg::edgeCode    hitEdge
);
	import pinballPkg::*;

	logic signed [11:0] ballRight;
	logic signed [11:0] ballBottom;
	logic signed [11:0] centreX;
	logic signed [11:0] centreY;
	edgeCode            wallEdge;
	edgeCode            bumperEdge;
	logic               bumperOverlap;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Ball box against walls and bumper
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_comb begin
		ballRight  = 12'(topLeftX) + 12'(`BALL_SIZE);
		ballBottom = 12'(topLeftY) + 12'(`BALL_SIZE);
		centreX    = 12'(topLeftX) + 12'(`BALL_SIZE / 2);
		centreY    = 12'(topLeftY) + 12'(`BALL_SIZE / 2);

		// Touching counts as a hit
		wallEdge              = '0;
		wallEdge[EDGE_LEFT]   = (topLeftX <= 0);
		wallEdge[EDGE_TOP]    = (topLeftY <= 0);
		wallEdge[EDGE_RIGHT]  = (ballRight >= `FIELD_WIDTH);
		wallEdge[EDGE_BOTTOM] = (ballBottom >= `FIELD_HEIGHT);

		bumperOverlap = (ballRight > `BUMPER_LEFT) && (topLeftX < `BUMPER_RIGHT) &&
			(ballBottom > `BUMPER_TOP) && (topLeftY < `BUMPER_BOTTOM);

		// Side picked from where the ball centre lies
		bumperEdge = '0;
		if (centreX < `BUMPER_LEFT) begin
			bumperEdge[EDGE_RIGHT] = 1'b1;
		end
		else if (centreX > `BUMPER_RIGHT) begin
			bumperEdge[EDGE_LEFT] = 1'b1;
		end
		else if (centreY < ((`BUMPER_TOP + `BUMPER_BOTTOM) / 2)) begin
			bumperEdge[EDGE_BOTTOM] = 1'b1;
		end
		else begin
			bumperEdge[EDGE_TOP] = 1'b1;
		end
	end

	// Flags cleared on the strobe while the ball moves
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			frameHit  <= 1'b0;
			bumperHit <= 1'b0;
			hitEdge   <= '0;
		end
		else if (startOfFrame) begin
			frameHit  <= 1'b0;
			bumperHit <= 1'b0;
			hitEdge   <= '0;
		end
		else begin
			frameHit  <= |wallEdge;
			bumperHit <= bumperOverlap;
			if (|wallEdge) begin
				hitEdge <= wallEdge;
			end
			else if (bumperOverlap) begin
				hitEdge <= bumperEdge;
			end
			else begin
				hitEdge <= '0;
			end
		end
	end

endmodule

`default_nettype wire

// ==== common/pinballPkg.sv ====
`default_nettype none

package pinballPkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Vector types
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// Pixel coordinate on screen
	typedef logic signed [10:0] screenCoord;

	// Position or speed scaled by the fixed-point multiplier
	typedef logic signed [31:0] fixedValue;

	// Ball-side contact edges {left, top, right, bottom}
	typedef logic [3:0] edgeCode;

	// Frame count for the cooldowns
	typedef logic [7:0] cooldownCount;

	// Clock-cycle count within one frame
	typedef logic [7:0] frameCycle;

	// Bit positions inside edgeCode
	localparam int EDGE_LEFT   = 3;
	localparam int EDGE_TOP    = 2;
	localparam int EDGE_RIGHT  = 1;
	localparam int EDGE_BOTTOM = 0;

endpackage

`default_nettype wire

// ==== common/pinball_defines.svh ====
`ifndef PINBALL_DEFINES_SVH
`define PINBALL_DEFINES_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Fixed point and motion
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define FIXED_SCALE      64
`define GRAVITY          5

// Playfield and ball in pixels
`define FIELD_WIDTH      480
`define FIELD_HEIGHT     640
`define BALL_SIZE        16
`define BALL_START_X     232
`define BALL_START_Y     40

// Bumper rectangle in pixels
`define BUMPER_LEFT      200
`define BUMPER_TOP       300
`define BUMPER_RIGHT     280
`define BUMPER_BOTTOM    340

// Cooldowns in frames
`define BUMPER_COOLDOWN  40
`define SPRING_COOLDOWN  5

// Clock cycles per frame
`define FRAME_PERIOD     64

`endif

// ==== design/frameTicker.sv ====
`default_nettype none
`include "pinball_defines.svh"

module frameTicker (
	input  logic clk,
	input  logic resetN,
	input  logic pause,
	output logic startOfFrame
);
	import pinballPkg::*;

	frameCycle cycleCnt;

	// Strobe is registered, so the first one lands FRAME_PERIOD cycles after reset
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			cycleCnt     <= '0;
			startOfFrame <= 1'b0;
		end
		else if (pause) begin
			startOfFrame <= 1'b0;
		end
		else if (cycleCnt == frameCycle'(`FRAME_PERIOD - 1)) begin
			cycleCnt     <= '0;
			startOfFrame <= 1'b1;
		end
		else begin
			cycleCnt     <= cycleCnt + 1'b1;
			startOfFrame <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// ==== design/pinballPhysics.sv ====
`default_nettype none

module pinballPhysics (
	input  logic                   clk,
	input  logic                   resetN,
	input  logic                   pause,
	input  logic                   resetLevel,
	input  logic                   trapActive,
	input  logic                   flipperHit,
	input  logic                   springHit,
	input  pinballPkg::fixedValue  flipperSpeedX,
	input  pinballPkg::fixedValue  springSpeedY,
	input  pinballPkg::screenCoord trapX,
	input  pinballPkg::screenCoord trapY,
	output pinballPkg::screenCoord topLeftX,
	output pinballPkg::screenCoord topLeftY,
	output logic                   startOfFrame
);
	import pinballPkg::*;

	logic    frameHit;
	logic    bumperHit;
	edgeCode hitEdge;

	frameTicker ticker (
		.clk          (clk),
		.resetN       (resetN),
		.pause        (pause),
		.startOfFrame (startOfFrame)
	);

	collisionUnit collision (
		.clk          (clk),
		.resetN       (resetN),
		.startOfFrame (startOfFrame),
		.topLeftX     (topLeftX),
		.topLeftY     (topLeftY),
		.frameHit     (frameHit),
		.bumperHit    (bumperHit),
		.hitEdge      (hitEdge)
	);

	ballController ball (
		.clk           (clk),
		.resetN        (resetN),
		.startOfFrame  (startOfFrame),
		.pause         (pause),
		.resetLevel    (resetLevel),
		.frameHit      (frameHit),
		.bumperHit     (bumperHit),
		.flipperHit    (flipperHit),
		.springHit     (springHit),
		.trapActive    (trapActive),
		.hitEdge       (hitEdge),
		.flipperSpeedX (flipperSpeedX),
		.springSpeedY  (springSpeedY),
		.trapX         (trapX),
		.trapY         (trapY),
		.topLeftX      (topLeftX),
		.topLeftY      (topLeftY)
	);

endmodule

`default_nettype wire

// ==== dv/pinballChecker.sv ====
`default_nettype none
`include "pinball_defines.svh"

module pinballChecker (
	input logic                   clk,
	input logic                   resetN,
	input logic                   startOfFrame,
	input pinballPkg::screenCoord topLeftX,
	input pinballPkg::screenCoord topLeftY
);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Strobe shape and ball position
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	strobeSingle: assert property (@(posedge clk) disable iff (!resetN)
		startOfFrame |=> !startOfFrame)
		else $error("startOfFrame high in two consecutive cycles");

	// First cycle out of reset
	startPosition: assert property (@(posedge clk)
		$rose(resetN) |-> (topLeftX == `BALL_START_X) && (topLeftY == `BALL_START_Y))
		else $error("ball not at its start position after reset");

	xInField: assert property (@(posedge clk) disable iff (!resetN)
		(topLeftX >= 0) && (topLeftX <= `FIELD_WIDTH))
		else $error("topLeftX outside the playfield");

endmodule

bind ballController pinballChecker ballCheck (
	.clk          (clk),
	.resetN       (resetN),
	.startOfFrame (startOfFrame),
	.topLeftX     (topLeftX),
	.topLeftY     (topLeftY)
);

`default_nettype wire

// ==== dv/pinballModel.svh ====
`ifndef PINBALL_MODEL_SVH
`define PINBALL_MODEL_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Reference state as fixed point in 32-bit ints
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
int      mPosX;
int      mPosY;
int      mSpeedX;
int      mSpeedY;
int      mBumperCool;
int      mSpringCool;
int      mCycle;
logic    mStrobe;
logic    mWall;
logic    mBumper;
edgeCode mEdge;

function automatic screenCoord pixelOf(input int fixedPos);
	return screenCoord'(fixedPos / `FIXED_SCALE);
endfunction

task automatic restartBall();
	mPosX       = `BALL_START_X * `FIXED_SCALE;
	mPosY       = `BALL_START_Y * `FIXED_SCALE;
	mSpeedX     = 0;
	mSpeedY     = 0;
	mBumperCool = 0;
	mSpringCool = 0;
endtask

task automatic modelReset();
	restartBall();
	mCycle  = 0;
	mStrobe = 1'b0;
	mWall   = 1'b0;
	mBumper = 1'b0;
	mEdge   = '0;
endtask

// Wall contact wins over the bumper
task automatic findContacts(input screenCoord x, input screenCoord y,
	output logic wall, output logic bump, output edgeCode edges);
	int      right;
	int      bottom;
	int      midX;
	int      midY;
	edgeCode wallSides;
	edgeCode bumpSides;
	right     = int'(x) + `BALL_SIZE;
	bottom    = int'(y) + `BALL_SIZE;
	midX      = int'(x) + `BALL_SIZE / 2;
	midY      = int'(y) + `BALL_SIZE / 2;
	wallSides = {x <= 0, y <= 0, right >= `FIELD_WIDTH, bottom >= `FIELD_HEIGHT};
	bump      = (right > `BUMPER_LEFT) && (int'(x) < `BUMPER_RIGHT) &&
		(bottom > `BUMPER_TOP) && (int'(y) < `BUMPER_BOTTOM);
	if (midX < `BUMPER_LEFT)
		bumpSides = 4'b0010;
	else if (midX > `BUMPER_RIGHT)
		bumpSides = 4'b1000;
	else if (midY < (`BUMPER_TOP + `BUMPER_BOTTOM) / 2)
		bumpSides = 4'b0001;
	else
		bumpSides = 4'b0100;
	wall  = |wallSides;
	edges = wall ? wallSides : (bump ? bumpSides : 4'b0000);
endtask

// One clock of ticker, collision flags and ball
task automatic modelStep();
	logic    wall;
	logic    bump;
	edgeCode edges;
	logic    frameNow;
	logic    wallNow;
	logic    bumpNow;
	edgeCode edgeNow;
	int      movedX;
	frameNow = mStrobe;
	wallNow  = mWall;
	bumpNow  = mBumper;
	edgeNow  = mEdge;
	findContacts(pixelOf(mPosX), pixelOf(mPosY), wall, bump, edges);

	if (!pause) begin
		mCycle = (mCycle + 1) % `FRAME_PERIOD;
	end
	mStrobe = !pause && (mCycle == 0);
	mWall   = !frameNow && wall;
	mBumper = !frameNow && bump;
	mEdge   = frameNow ? 4'b0000 : edges;

	if (resetLevel) begin
		restartBall();
	end
	else if (!pause) begin
		if (trapActive) begin
			mPosX = (int'(trapX) - `BALL_SIZE / 2) * `FIXED_SCALE;
			mPosY = (int'(trapY) - `BALL_SIZE / 2) * `FIXED_SCALE;
		end
		else if (frameNow) begin
			movedX  = mPosX + mSpeedX;
			mPosY   = mPosY + mSpeedY;
			mSpeedY = mSpeedY + `GRAVITY;
			if (movedX < 0 || movedX > `FIELD_WIDTH * `FIXED_SCALE)
				mSpeedX = mSpeedX >>> 1;
			else
				mPosX = movedX;
			mBumperCool = (mBumperCool > 0) ? mBumperCool - 1 : 0;
			mSpringCool = (mSpringCool > 0) ? mSpringCool - 1 : 0;
		end
		else if (wallNow) begin
			if ((edgeNow[EDGE_LEFT] && mSpeedX < 0) || (edgeNow[EDGE_RIGHT] && mSpeedX > 0))
				mSpeedX = -mSpeedX;
			if ((edgeNow[EDGE_TOP] && mSpeedY < 0) || (edgeNow[EDGE_BOTTOM] && mSpeedY > 0))
				mSpeedY = -mSpeedY;
		end
		else if (springHit && mSpringCool == 0) begin
			mSpeedY     = (springSpeedY < 0) ? int'(springSpeedY) - mSpeedY : -mSpeedY;
			mSpringCool = `SPRING_COOLDOWN;
		end
		else if (flipperHit) begin
			if (mSpeedY > 0) begin
				mSpeedY = -mSpeedY;
				mSpeedX = mSpeedX + int'(flipperSpeedX);
			end
		end
		else if (bumpNow && mBumperCool == 0) begin
			if ((edgeNow[EDGE_LEFT] && mSpeedX < 0) || (edgeNow[EDGE_RIGHT] && mSpeedX > 0))
				mSpeedX = -2 * mSpeedX;
			if ((edgeNow[EDGE_TOP] && mSpeedY < 0) || (edgeNow[EDGE_BOTTOM] && mSpeedY > 0))
				mSpeedY = -2 * mSpeedY;
			mBumperCool = `BUMPER_COOLDOWN;
		end
	end
endtask

`endif

// ==== dv/pinballTb.sv ====
`default_nettype none
`include "pinball_defines.svh"

module pinballTb;
	import pinballPkg::*;

	localparam int FALL_CYCLES    = 9000;
	localparam int HIT_CYCLES     = 8000;
	localparam int REBOUND_CYCLES = 1950;
	localparam int SINK_CYCLES    = 3000;
	localparam int CONTROL_CYCLES = 5000;
	localparam int TOTAL_CYCLES   = 10 + FALL_CYCLES + HIT_CYCLES + REBOUND_CYCLES +
		SINK_CYCLES + CONTROL_CYCLES + 16;

	logic       clk;
	logic       resetN;
	logic       pause;
	logic       resetLevel;
	logic       trapActive;
	logic       flipperHit;
	logic       springHit;
	fixedValue  flipperSpeedX;
	fixedValue  springSpeedY;
	screenCoord trapX;
	screenCoord trapY;
	screenCoord topLeftX;
	screenCoord topLeftY;
	logic       startOfFrame;
	int         seed;
	int         coordErrors;
	int         strobeErrors;

	`include "pinballModel.svh"

	pinballPhysics dut (
		.clk           (clk),
		.resetN        (resetN),
		.pause         (pause),
		.resetLevel    (resetLevel),
		.trapActive    (trapActive),
		.flipperHit    (flipperHit),
		.springHit     (springHit),
		.flipperSpeedX (flipperSpeedX),
		.springSpeedY  (springSpeedY),
		.trapX         (trapX),
		.trapY         (trapY),
		.topLeftX      (topLeftX),
		.topLeftY      (topLeftY),
		.startOfFrame  (startOfFrame)
	);

	always #20 clk = ~clk;

	always @(posedge clk) begin
		if (!resetN)
			modelReset();
		else
			modelStep();
	end

	// Outputs settle well before the falling edge
	always @(negedge clk) begin
		if (resetN) begin
			checkScreenCoord("topLeftX", topLeftX, pixelOf(mPosX));
			checkScreenCoord("topLeftY", topLeftY, pixelOf(mPosY));
			checkStrobe("startOfFrame", startOfFrame, mStrobe);
		end
	end

	task automatic checkScreenCoord(input string name, input screenCoord actual,
		input screenCoord expected);
		if (actual !== expected) begin
			coordErrors++;
			$display("CHECK FAILED t=%0t %s: got %0d, expected %0d", $time, name, actual,
				expected);
		end
	endtask

	task automatic checkStrobe(input string name, input logic actual, input logic expected);
		if (actual !== expected) begin
			strobeErrors++;
			$display("CHECK FAILED t=%0t %s: got %b, expected %b", $time, name, actual,
				expected);
		end
	endtask

	// Inputs go back to idle each cycle unless the caller sets them
	task automatic nextCycle();
		@(posedge clk);
		#2;
		pause      = 1'b0;
		resetLevel = 1'b0;
		trapActive = 1'b0;
		flipperHit = 1'b0;
		springHit  = 1'b0;
	endtask

	task automatic idle(input int cycles);
		repeat (cycles) nextCycle();
	endtask

	task automatic trapAt(input int x, input int y);
		nextCycle();
		trapActive = 1'b1;
		trapX      = screenCoord'(x);
		trapY      = screenCoord'(y);
	endtask

	task automatic randomStrikes(input int cycles);
		repeat (cycles) begin
			nextCycle();
			flipperHit    = ($random(seed) & 63) == 0;
			springHit     = ($random(seed) & 127) == 0;
			flipperSpeedX = fixedValue'($random(seed) % 200);
			springSpeedY  = fixedValue'($random(seed) % 250 - 60);
		end
	endtask

	task automatic randomControls(input int cycles);
		repeat (cycles) begin
			nextCycle();
			pause      = ($random(seed) & 7) < 3;
			resetLevel = ($random(seed) & 511) == 0;
			if (($random(seed) & 255) == 0) begin
				trapActive = 1'b1;
				trapX      = screenCoord'(8 + ($random(seed) & 32'h7fffffff) % 465);
				trapY      = screenCoord'(8 + ($random(seed) & 32'h7fffffff) % 625);
			end
		end
	endtask

	initial begin
		clk           = 1'b0;
		resetN        = 1'b0;
		pause         = 1'b0;
		resetLevel    = 1'b0;
		trapActive    = 1'b0;
		flipperHit    = 1'b0;
		springHit     = 1'b0;
		flipperSpeedX = '0;
		springSpeedY  = '0;
		trapX         = '0;
		trapY         = '0;
		seed          = 32'h5d2771e6;
		coordErrors   = 0;
		strobeErrors  = 0;
		repeat (10) @(posedge clk);
		#2;
		resetN = 1'b1;

		// Free fall near the left wall down to the floor
		trapAt(60, 100);
		idle(FALL_CYCLES);

		nextCycle();
		resetLevel = 1'b1;
		trapAt(80, 200);
		randomStrikes(HIT_CYCLES);

		// Drop onto the bumper, then send the ball back while it cools
		nextCycle();
		resetLevel = 1'b1;
		trapAt(240, 270);
		idle(REBOUND_CYCLES);
		nextCycle();
		springHit    = 1'b1;
		springSpeedY = '0;
		idle(SINK_CYCLES);

		randomControls(CONTROL_CYCLES);
		idle(4);

		$display("Errors: %0d coordinate, %0d strobe", coordErrors, strobeErrors);
		if (coordErrors + strobeErrors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

	initial begin
		#((TOTAL_CYCLES + 1000) * 40);
		$display("Watchdog expired before the tests finished");
		$display("Regression failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# Build with Verilator, run, and look for the pass line in the output
verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module pinballTb \
	-o pinballSim &&
	./obj_dir/pinballSim | tee /dev/stderr | grep -q "^Regression passed$" &&
	echo "PASS" ||
	{ echo "FAIL"; exit 1; }

// ==== sim.f ====
+incdir+common
+incdir+dv
common/pinballPkg.sv
design/frameTicker.sv
ball/collisionUnit.sv
ball/ballController.sv
design/pinballPhysics.sv
dv/pinballChecker.sv
dv/pinballTb.sv
